//--- src/vfxp_arch_pkg.sv
//****************************************
// Architectural encodings of the vector fixed-point add/subtract group
// Opcode values are local to this unit, not the RVV instruction encoding
// Rounding mode values follow the vxrm CSR field
//****************************************
`default_nettype none

package vfxp_arch_pkg;

    // Saturating and averaging add/subtract, vd = vs2 op vs1
    typedef enum logic [2:0] {
        VSADDU = 3'd0,
        VSADD  = 3'd1,
        VSSUBU = 3'd2,
        VSSUB  = 3'd3,
        VAADDU = 3'd4,
        VAADD  = 3'd5,
        VASUBU = 3'd6,
        VASUB  = 3'd7
    } vfxp_op_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } vfxp_sew_t;

    typedef enum logic [1:0] {
        RNU_V = 2'd0,   // Round to nearest up
        RNE_V = 2'd1,   // Round to nearest even
        RDN_V = 2'd2,   // Truncate
        ROD_V = 2'd3    // Round to odd
    } vfxp_vxrm_t;

endpackage

`default_nettype wire

//--- src/vfxp_uarch_pkg.sv
//****************************************
// Implementation constants of the lane
// DATA_W must stay a multiple of 8
//****************************************
`default_nettype none

package vfxp_uarch_pkg;

    localparam int unsigned DATA_W   = 64;
    localparam int unsigned LANES    = DATA_W / 8;  // One byte adder per lane

    // Request edge to result edge, issue plus execute register
    localparam int unsigned PIPE_LAT = 2;

endpackage

`default_nettype wire

//--- src/vfxp_issue_stage.sv
//****************************************
// Issue register of the lane
// Request fields are sampled only with valid_i
// Scalar operand uses the low SEW bits of scalar_i
//****************************************
`default_nettype none

module vfxp_issue_stage
    import vfxp_arch_pkg::*;
    import vfxp_uarch_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  vfxp_op_t            op_i,
    input  vfxp_sew_t           sew_i,
    input  vfxp_vxrm_t          vxrm_i,
    input  logic                src_scalar_i,
    input  logic [DATA_W-1:0]   scalar_i,
    input  logic [DATA_W-1:0]   vs1_i,
    input  logic [DATA_W-1:0]   vs2_i,
    output logic                valid_o,
    output vfxp_op_t            op_o,
    output vfxp_sew_t           sew_o,
    output vfxp_vxrm_t          vxrm_o,
    output logic [DATA_W-1:0]   vs1_o,
    output logic [DATA_W-1:0]   vs2_o
);

    logic [DATA_W-1:0] scalar_rep;

    // Splat the scalar over all elements of the current width
    always_comb begin
        case (sew_i)
            SEW_8:   scalar_rep = {(DATA_W / 8){scalar_i[7:0]}};
            SEW_16:  scalar_rep = {(DATA_W / 16){scalar_i[15:0]}};
            SEW_32:  scalar_rep = {(DATA_W / 32){scalar_i[31:0]}};
            default: scalar_rep = scalar_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            op_o   <= op_i;
            sew_o  <= sew_i;
            vxrm_o <= vxrm_i;
            vs1_o  <= src_scalar_i ? scalar_rep : vs1_i;   // vx form
            vs2_o  <= vs2_i;
        end
    end

endmodule

`default_nettype wire

//--- src/vsaaddsub.sv
//****************************************
// Combinational saturating / averaging add and subtract, vd = vs2 op vs1
// Eight byte adders, carries chained inside an element
// Averaging rounds by vxrm_i and never reports saturation
// Outputs are meaningful for every input, no valid qualifier here
//****************************************
`default_nettype none

module vsaaddsub
    import vfxp_arch_pkg::*;
    import vfxp_uarch_pkg::*;
(
    input  vfxp_op_t            instr_type_i,
    input  vfxp_sew_t           sew_i,
    input  vfxp_vxrm_t          vxrm_i,
    input  logic [DATA_W-1:0]   data_vs1_i,
    input  logic [DATA_W-1:0]   data_vs2_i,
    output logic [DATA_W-1:0]   data_vd_o,
    output logic                sat_ovf_o
);

    logic                   is_sub;
    logic                   is_signed;
    logic                   is_avg;

    logic [3:0]             elem_mask;      // Element size in bytes, minus one
    logic [LANES-1:0]       elem_start;     // Lowest byte of an element
    logic [LANES-1:0]       elem_top;       // Highest byte of an element

    logic [LANES-1:0][7:0]  opa;
    logic [LANES-1:0][7:0]  opb;
    logic [LANES-1:0][7:0]  sum;
    logic [LANES-1:0]       cout;
    logic                   carry;

    logic [LANES-1:0]       ovf;            // Meaningful on top bytes
    logic [LANES-1:0]       ninth;          // Bit n of the exact n+1 bit result
    logic [LANES-1:0]       rnd;            // Rounding increment, start bytes
    logic                   elem_ovf;
    logic                   elem_neg;
    logic [LANES-1:0]       byte_ovf;
    logic [LANES-1:0]       byte_neg;

    logic [DATA_W-1:0]      sum_shr;
    logic [7:0]             half;
    logic                   inc;
    logic [LANES-1:0][7:0]  avg;

    assign is_sub    = instr_type_i inside {VSSUBU, VSSUB, VASUBU, VASUB};
    assign is_signed = instr_type_i inside {VSADD, VSSUB, VAADD, VASUB};
    assign is_avg    = instr_type_i inside {VAADDU, VAADD, VASUBU, VASUB};

    // Element boundaries from the byte index
    always_comb begin
        elem_mask = (4'd1 << sew_i) - 4'd1;
        for (int i = 0; i < LANES; i++) begin
            elem_start[i] = (4'(i) & elem_mask) == 4'd0;
            elem_top[i]   = (4'(i) & elem_mask) == elem_mask;
        end
    end

    // Byte adders, subtraction as vs2 + ~vs1 + 1
    always_comb begin
        carry = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            opa[i] = data_vs2_i[8*i +: 8];
            opb[i] = is_sub ? ~data_vs1_i[8*i +: 8] : data_vs1_i[8*i +: 8];
            if (elem_start[i]) begin
                carry = is_sub;     // Fresh element
            end
            {cout[i], sum[i]} = opa[i] + opb[i] + carry;
            carry = cout[i];
        end
    end

    // Per byte flags, only top / start bytes are looked at later
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            case (instr_type_i)
                VSADDU:       ovf[i] = cout[i];
                VSSUBU:       ovf[i] = ~cout[i];     // Borrow out
                VSADD, VSSUB: ovf[i] = (opa[i][7] ^ sum[i][7]) & (opb[i][7] ^ sum[i][7]);
                default:      ovf[i] = 1'b0;
            endcase

            // Sign or zero extended operands summed one bit further
            if (is_signed) begin
                ninth[i] = opa[i][7] ^ opb[i][7] ^ cout[i];
            end else begin
                ninth[i] = is_sub ^ cout[i];
            end

            // Shift by one, so the dropped part is bit 0 alone
            case (vxrm_i)
                RNU_V:   rnd[i] = sum[i][0];
                RNE_V:   rnd[i] = sum[i][0] & sum[i][1];
                RDN_V:   rnd[i] = 1'b0;
                default: rnd[i] = sum[i][0] & ~sum[i][1];   // ROD_V
            endcase
        end
    end

    // Spread the overflow and operand sign of each element down to its bytes
    always_comb begin
        elem_ovf = 1'b0;
        elem_neg = 1'b0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (elem_top[i]) begin
                elem_ovf = ovf[i];
                elem_neg = opa[i][7];
            end
            byte_ovf[i] = elem_ovf;
            byte_neg[i] = elem_neg;
        end
    end

    assign sum_shr = sum >> 1;

    // Averaging result, (n+1 bit sum >> 1) plus rounding, incremented byte by byte
    always_comb begin
        inc  = 1'b0;
        half = 8'h00;
        for (int i = 0; i < LANES; i++) begin
            half = {elem_top[i] ? ninth[i] : sum_shr[8*i+7], sum_shr[8*i +: 7]};
            if (elem_start[i]) begin
                inc = rnd[i];
            end
            {inc, avg[i]} = half + inc;
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (is_avg) begin
                data_vd_o[8*i +: 8] = avg[i];
            end else if (!byte_ovf[i]) begin
                data_vd_o[8*i +: 8] = sum[i];
            end else if (is_signed) begin
                // Clamp toward the sign of vs2, 0x7F.. or 0x80..
                if (elem_top[i]) begin
                    data_vd_o[8*i +: 8] = byte_neg[i] ? 8'h80 : 8'h7F;
                end else begin
                    data_vd_o[8*i +: 8] = byte_neg[i] ? 8'h00 : 8'hFF;
                end
            end else begin
                data_vd_o[8*i +: 8] = is_sub ? 8'h00 : 8'hFF;
            end
        end
    end

    assign sat_ovf_o = |(ovf & elem_top);

endmodule

`default_nettype wire

//--- src/vfxp_exec_stage.sv
//****************************************
// Execute register around vsaaddsub
// sat_o is a one cycle pulse per saturating result
//****************************************
`default_nettype none

module vfxp_exec_stage
    import vfxp_arch_pkg::*;
    import vfxp_uarch_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  vfxp_op_t            op_i,
    input  vfxp_sew_t           sew_i,
    input  vfxp_vxrm_t          vxrm_i,
    input  logic [DATA_W-1:0]   vs1_i,
    input  logic [DATA_W-1:0]   vs2_i,
    output logic                valid_o,
    output logic [DATA_W-1:0]   result_o,
    output logic                sat_o
);

    logic [DATA_W-1:0] vd;
    logic              ovf;

    vsaaddsub i_vsaaddsub (
        .instr_type_i (op_i),
        .sew_i        (sew_i),
        .vxrm_i       (vxrm_i),
        .data_vs1_i   (vs1_i),
        .data_vs2_i   (vs2_i),
        .data_vd_o    (vd),
        .sat_ovf_o    (ovf)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            sat_o   <= 1'b0;
        end else begin
            valid_o <= valid_i;
            sat_o   <= valid_i & ovf;   // Bubbles carry stale operands
        end
    end

    always_ff @(posedge clk_i) begin
        result_o <= vd;
    end

endmodule

`default_nettype wire

//--- src/vfxp_vxsat_csr.sv
//****************************************
// Sticky vxsat bit
// vxsat_o shows a set in the cycle it arrives
// Set wins over a clear in the same cycle
//****************************************
`default_nettype none

module vfxp_vxsat_csr (
    input  logic clk_i,
    input  logic rst_i,
    input  logic set_i,
    input  logic clr_i,
    output logic vxsat_o
);

    logic sat_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sat_q <= 1'b0;
        end else if (set_i) begin
            sat_q <= 1'b1;
        end else if (clr_i) begin
            sat_q <= 1'b0;
        end
    end

    // Visible together with the saturating result
    assign vxsat_o = sat_q | set_i;

endmodule

`default_nettype wire

//--- src/vfxp_top.sv
//****************************************
// Vector fixed-point add/subtract lane
// Fixed PIPE_LAT latency, no back-pressure, one request per cycle max
// No masking, vl or tail handling
//****************************************
`default_nettype none

module vfxp_top
    import vfxp_arch_pkg::*;
    import vfxp_uarch_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  vfxp_op_t            op_i,
    input  vfxp_sew_t           sew_i,
    input  vfxp_vxrm_t          vxrm_i,
    input  logic                src_scalar_i,
    input  logic [DATA_W-1:0]   scalar_i,
    input  logic [DATA_W-1:0]   vs1_i,
    input  logic [DATA_W-1:0]   vs2_i,
    input  logic                vxsat_clr_i,
    output logic                result_valid_o,
    output logic [DATA_W-1:0]   result_o,
    output logic                vxsat_o
);

    logic              iss_valid;
    vfxp_op_t          iss_op;
    vfxp_sew_t         iss_sew;
    vfxp_vxrm_t        iss_vxrm;
    logic [DATA_W-1:0] iss_vs1;
    logic [DATA_W-1:0] iss_vs2;
    logic              ex_sat;

    // Two registers below, issue and execute
    if (PIPE_LAT != 2) begin : g_lat_check
        $error("PIPE_LAT does not match the issue plus execute stages");
    end

    vfxp_issue_stage i_issue (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .sew_i        (sew_i),
        .vxrm_i       (vxrm_i),
        .src_scalar_i (src_scalar_i),
        .scalar_i     (scalar_i),
        .vs1_i        (vs1_i),
        .vs2_i        (vs2_i),
        .valid_o      (iss_valid),
        .op_o         (iss_op),
        .sew_o        (iss_sew),
        .vxrm_o       (iss_vxrm),
        .vs1_o        (iss_vs1),
        .vs2_o        (iss_vs2)
    );

    vfxp_exec_stage i_exec (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .valid_i  (iss_valid),
        .op_i     (iss_op),
        .sew_i    (iss_sew),
        .vxrm_i   (iss_vxrm),
        .vs1_i    (iss_vs1),
        .vs2_i    (iss_vs2),
        .valid_o  (result_valid_o),
        .result_o (result_o),
        .sat_o    (ex_sat)
    );

    vfxp_vxsat_csr i_vxsat (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .set_i   (ex_sat),
        .clr_i   (vxsat_clr_i),
        .vxsat_o (vxsat_o)
    );

endmodule

`default_nettype wire

//--- testbench/vfxp_sva.sv
//****************************************
// Bound checker that sees only the ports of vfxp_top
// Reference model works per element in DATA_W+2 bit signed arithmetic
// Each failed check increments err_count, which the testbench watches
//****************************************
`default_nettype none

module vfxp_sva
    import vfxp_arch_pkg::*;
    import vfxp_uarch_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  vfxp_op_t            op_i,
    input  vfxp_sew_t           sew_i,
    input  vfxp_vxrm_t          vxrm_i,
    input  logic                src_scalar_i,
    input  logic [DATA_W-1:0]   scalar_i,
    input  logic [DATA_W-1:0]   vs1_i,
    input  logic [DATA_W-1:0]   vs2_i,
    input  logic                vxsat_clr_i,
    input  logic                result_valid_o,
    input  logic [DATA_W-1:0]   result_o,
    input  logic                vxsat_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int err_count = 0;

    logic [DATA_W:0] expect_now;    // {saturated, vd} for the current inputs
    logic            sat_req;

    // Exact vd = vs2 op vs1 with the saturation flag as the top bit
    function automatic logic [DATA_W:0] reference_result(
        input vfxp_op_t          op,
        input vfxp_sew_t         sew,
        input vfxp_vxrm_t        vxrm,
        input logic              use_scalar,
        input logic [DATA_W-1:0] scalar,
        input logic [DATA_W-1:0] vs1,
        input logic [DATA_W-1:0] vs2
    );
        int unsigned              w;
        logic signed [DATA_W+1:0] lim;
        logic signed [DATA_W+1:0] mask;
        logic signed [DATA_W+1:0] a;
        logic signed [DATA_W+1:0] b;
        logic signed [DATA_W+1:0] s;
        logic signed [DATA_W+1:0] hi;
        logic signed [DATA_W+1:0] lo;
        logic signed [DATA_W+1:0] r;
        logic [DATA_W-1:0]        vd;
        logic                     sat;
        logic                     rnd;
        logic                     sgn;
        logic                     sub;
        logic                     avg;

        sgn = op inside {VSADD, VSSUB, VAADD, VASUB};
        sub = op inside {VSSUBU, VSSUB, VASUBU, VASUB};
        avg = op inside {VAADDU, VAADD, VASUBU, VASUB};
        w   = 8 << sew;
        lim = '0;
        lim[w] = 1'b1;              // 2**w
        mask = lim - 1;
        hi  = sgn ? (lim >>> 1) - 1 : lim - 1;
        lo  = sgn ? -(lim >>> 1) : '0;
        vd  = '0;
        sat = 1'b0;
        for (int e = 0; e < DATA_W / w; e++) begin
            a = (DATA_W+2)'(vs2 >> (e * w)) & mask;
            b = use_scalar ? (DATA_W+2)'(scalar) & mask : (DATA_W+2)'(vs1 >> (e * w)) & mask;
            if (sgn && a[w-1]) a = a - lim;
            if (sgn && b[w-1]) b = b - lim;
            s = sub ? a - b : a + b;
            if (avg) begin
                case (vxrm)
                    RNU_V:   rnd = s[0];
                    RNE_V:   rnd = s[0] & s[1];
                    RDN_V:   rnd = 1'b0;
                    default: rnd = s[0] & ~s[1];
                endcase
                r = (s >>> 1) + rnd;
            end else if (s > hi) begin
                r   = hi;
                sat = 1'b1;
            end else if (s < lo) begin
                r   = lo;
                sat = 1'b1;
            end else begin
                r = s;
            end
            vd = vd | (DATA_W'(r & mask) << (e * w));
        end
        return {sat, vd};
    endfunction

    assign expect_now = reference_result(op_i, sew_i, vxrm_i, src_scalar_i, scalar_i,
                                         vs1_i, vs2_i);
    assign sat_req    = valid_i & expect_now[DATA_W];

    a_reset_clears: assert property (@(posedge clk_i) rst_i |=> !result_valid_o && !vxsat_o)
        else begin
            $error("valid or vxsat not low after reset");
            err_count++;
        end

    a_valid_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        result_valid_o == $past(valid_i, PIPE_LAT))
        else begin
            $error("result_valid_o pulse does not match a request");
            err_count++;
        end

    a_result_value: assert property (@(posedge clk_i) disable iff (rst_i)
        $past(valid_i, PIPE_LAT) |-> result_o == $past(expect_now[DATA_W-1:0], PIPE_LAT))
        else begin
            $error("result_o differs from the reference model");
            err_count++;
        end

    // Sticky flag rises with the result and a set beats a clear
    a_vxsat_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
        vxsat_o == ($past(sat_req, PIPE_LAT) | $past(sat_req, PIPE_LAT + 1)
                    | ($past(vxsat_o) & !$past(vxsat_clr_i))))
        else begin
            $error("vxsat_o differs from the expected flag");
            err_count++;
        end

endmodule

`default_nettype wire

//--- testbench/vfxp_tb.sv
//****************************************
// Testbench for vfxp_top with all checks in the bound vfxp_sva
// Inputs change on the falling edge only
// Run stops at the first checker error or at MAX_CYCLES
//****************************************
`default_nettype none

module vfxp_tb
    import vfxp_arch_pkg::*;
    import vfxp_uarch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned MAX_CYCLES = 2000;

    logic              clk;
    logic              rst;
    logic              valid;
    vfxp_op_t          op;
    vfxp_sew_t         sew;
    vfxp_vxrm_t        vxrm;
    logic              src_scalar;
    logic [DATA_W-1:0] scalar;
    logic [DATA_W-1:0] vs1;
    logic [DATA_W-1:0] vs2;
    logic              vxsat_clr;
    integer            seed = 90888;
    int unsigned       cycle_count = 0;

    // Outputs are observed by the bound checker
    vfxp_top i_vfxp_top (
        .clk_i (clk), .rst_i (rst), .valid_i (valid), .op_i (op), .sew_i (sew),
        .vxrm_i (vxrm), .src_scalar_i (src_scalar), .scalar_i (scalar), .vs1_i (vs1),
        .vs2_i (vs2), .vxsat_clr_i (vxsat_clr), .result_valid_o (),
        .result_o (), .vxsat_o ()
    );

    bind vfxp_top vfxp_sva i_sva (
        .clk_i (clk_i), .rst_i (rst_i), .valid_i (valid_i), .op_i (op_i), .sew_i (sew_i),
        .vxrm_i (vxrm_i), .src_scalar_i (src_scalar_i), .scalar_i (scalar_i),
        .vs1_i (vs1_i), .vs2_i (vs2_i), .vxsat_clr_i (vxsat_clr_i),
        .result_valid_o (result_valid_o), .result_o (result_o), .vxsat_o (vxsat_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // Repeat the low element of x over the whole vector
    function automatic logic [DATA_W-1:0] fill_elements(input vfxp_sew_t s,
                                                        input logic [DATA_W-1:0] x);
        int unsigned       w;
        logic [DATA_W-1:0] out;
        w   = 8 << s;
        out = (w == DATA_W) ? x : x & ((64'd1 << w) - 64'd1);
        for (int k = w; k < DATA_W; k = 2 * k) out = out | (out << k);
        return out;
    endfunction

    task automatic send_request(input vfxp_op_t o, input vfxp_sew_t s, input vfxp_vxrm_t rm,
                                input logic use_scalar, input logic [DATA_W-1:0] sc,
                                input logic [DATA_W-1:0] a1, input logic [DATA_W-1:0] a2,
                                input logic clr);
        @(negedge clk);
        valid      = 1'b1;
        op         = o;
        sew        = s;
        vxrm       = rm;
        src_scalar = use_scalar;
        scalar     = sc;
        vs1        = a1;
        vs2        = a2;
        vxsat_clr  = clr;
    endtask

    task automatic idle_cycles(input int count, input logic clr);
        repeat (count) begin
            @(negedge clk);
            valid     = 1'b0;
            vxsat_clr = clr;
        end
    endtask

    // Element limits as vs2 against small and all-ones vs1
    task automatic saturation_corners();
        vfxp_sew_t         s;
        logic [DATA_W-1:0] min_s;
        logic [DATA_W-1:0] max_s;
        logic [DATA_W-1:0] one;
        logic [DATA_W-1:0] ones;
        for (int si = 0; si < 4; si++) begin
            s     = vfxp_sew_t'(si);
            min_s = fill_elements(s, 64'd1 << ((8 << si) - 1));
            max_s = fill_elements(s, (64'd1 << ((8 << si) - 1)) - 64'd1);
            one   = fill_elements(s, 64'd1);
            ones  = '1;
            for (int oi = 0; oi < 8; oi++) begin
                send_request(vfxp_op_t'(oi), s, RNU_V, 1'b0, '0, one, max_s, 1'b0);
                send_request(vfxp_op_t'(oi), s, RNU_V, 1'b0, '0, one, min_s, 1'b0);
                send_request(vfxp_op_t'(oi), s, RNU_V, 1'b0, '0, one, ones, 1'b0);
                send_request(vfxp_op_t'(oi), s, RNU_V, 1'b0, '0, one, '0, 1'b0);
                send_request(vfxp_op_t'(oi), s, RNU_V, 1'b0, '0, ones, max_s, 1'b0);
            end
            idle_cycles(PIPE_LAT + 1, 1'b1);    // Clear once the flag has settled
        end
    endtask

    task automatic rounding_sweep();
        for (int si = 0; si < 4; si++) begin
            for (int oi = 4; oi < 8; oi++) begin
                for (int ri = 0; ri < 4; ri++) begin
                    send_request(vfxp_op_t'(oi), vfxp_sew_t'(si), vfxp_vxrm_t'(ri), 1'b0, '0,
                                 64'h0F1E_2D3C_4B5A_6978, 64'h0123_4567_89AB_CDEF, 1'b0);
                    send_request(vfxp_op_t'(oi), vfxp_sew_t'(si), vfxp_vxrm_t'(ri), 1'b0, '0,
                                 64'h0123_4567_89AB_CDEF, 64'h0F1E_2D3C_4B5A_6978, 1'b0);
                end
            end
        end
    endtask

    // vs1 carries junk so only the scalar can explain a correct result
    task automatic scalar_splat_cases();
        for (int si = 0; si < 4; si++) begin
            send_request(VSADDU, vfxp_sew_t'(si), RNU_V, 1'b1, 64'h8899_AABB_CCDD_EEF1,
                         64'hDEAD_BEEF_DEAD_BEEF, 64'h0102_0304_0506_0708, 1'b0);
            send_request(VASUB, vfxp_sew_t'(si), RNE_V, 1'b1, 64'h0000_0000_8000_7F81,
                         64'h5555_5555_5555_5555, 64'hF0E1_D2C3_B4A5_9687, 1'b0);
        end
    endtask

    task automatic random_traffic(input int count);
        integer            r;
        logic [DATA_W-1:0] sc;
        logic [DATA_W-1:0] a1;
        logic [DATA_W-1:0] a2;
        for (int k = 0; k < count; k++) begin
            r  = $random(seed);
            sc = {$random(seed), $random(seed)};
            a1 = {$random(seed), $random(seed)};
            a2 = {$random(seed), $random(seed)};
            if (r[1:0] == 2'd0) idle_cycles(1 + r[3:2], r[7:4] == 4'd0);
            send_request(vfxp_op_t'(r[10:8]), vfxp_sew_t'(r[12:11]), vfxp_vxrm_t'(r[14:13]),
                         r[15], sc, a1, a2, r[19:16] == 4'd0);
        end
    endtask

    // First failed assertion ends the run
    initial begin
        wait (i_vfxp_top.i_sva.err_count != 0);
        $display("Error at %0t ns: DUT result or vxsat differs from the expected value",
                 $time);
        stop_on_failure();
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: the run hung and did not finish within %0d cycles", MAX_CYCLES);
            stop_on_failure();
        end
    end

    initial begin
        rst        = 1'b1;
        valid      = 1'b0;
        op         = VSADDU;
        sew        = SEW_8;
        vxrm       = RNU_V;
        src_scalar = 1'b0;
        scalar     = '0;
        vs1        = '0;
        vs2        = '0;
        vxsat_clr  = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        idle_cycles(2, 1'b0);
        saturation_corners();
        rounding_sweep();
        scalar_splat_cases();
        random_traffic(400);
        idle_cycles(PIPE_LAT + 4, 1'b0);    // Drain
        if (i_vfxp_top.i_sva.err_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

//--- src.f
src/vfxp_arch_pkg.sv
src/vfxp_uarch_pkg.sv
src/vfxp_issue_stage.sv
src/vsaaddsub.sv
src/vfxp_exec_stage.sv
src/vfxp_vxsat_csr.sv
src/vfxp_top.sv
testbench/vfxp_sva.sv
testbench/vfxp_tb.sv

//--- Bender.yml
package:
  name: vfxp

sources:
  - src/vfxp_arch_pkg.sv
  - src/vfxp_uarch_pkg.sv
  - src/vfxp_issue_stage.sv
  - src/vsaaddsub.sv
  - src/vfxp_exec_stage.sv
  - src/vfxp_vxsat_csr.sv
  - src/vfxp_top.sv
  - target: test
    files:
      - testbench/vfxp_sva.sv
      - testbench/vfxp_tb.sv
